//--- mccu_pkg.sv
`default_nettype none

// Shared sizing and types for the maximum-contention control unit
package mccu_pkg;

    // Number of cores watched by the unit
    localparam int N_CORES = 2;

    // Contention events reported by each core
    localparam int CORE_EVENTS = 4;

    // Width of the software quota register
    localparam int QUOTA_WIDTH = 32;

    // Width of one event weight
    // A weight of zero disables its event
    localparam int WEIGHT_WIDTH = 7;

    // Sum of CORE_EVENTS weights at their maximum never wraps
    localparam int SUM_WIDTH = WEIGHT_WIDTH + $clog2(CORE_EVENTS);

    // One quota value
    typedef logic [QUOTA_WIDTH-1:0] quota_t;

    // One event weight
    typedef logic [WEIGHT_WIDTH-1:0] weight_t;

    // Consumed budget of one core in one cycle
    typedef logic [SUM_WIDTH-1:0] ccc_sum_t;

    // Event inputs of one core
    // Bit e of events selects weights[e] for this cycle
    typedef struct packed {
        logic [CORE_EVENTS-1:0]    events;
        weight_t [CORE_EVENTS-1:0] weights;
    } core_events_t;

    // Software control of one core's quota
    // Update is a level and new_quota is taken on every edge it is high
    typedef struct packed {
        logic   update;
        quota_t new_quota;
    } quota_ctrl_t;

endpackage : mccu_pkg

`default_nettype wire

//--- mccu_event_weigher.sv
`timescale 1ns/1ps
`default_nettype none

// Per-core weighted event adder
// Each cycle the active events of a core select their weights,
// the selected weights are added and the total is registered
module mccu_event_weigher (
    input  wire logic                                         clk_i,
    input  wire logic                                         rstn_i,
    input  wire mccu_pkg::core_events_t [mccu_pkg::N_CORES-1:0] core_events_i,
    output      mccu_pkg::ccc_sum_t     [mccu_pkg::N_CORES-1:0] ccc_sum_o
);

    import mccu_pkg::*;

    for (genvar c = 0; c < N_CORES; c++) begin : g_core

        // Weights that survive the event mask this cycle
        weight_t [CORE_EVENTS-1:0] gated_w;

        // Unregistered total for this core
        ccc_sum_t sum_d;

        // Registered total, seen by the quota monitor one edge later
        ccc_sum_t sum_q;

        // Inactive events contribute nothing
        for (genvar e = 0; e < CORE_EVENTS; e++) begin : g_event
            assign gated_w[e] = core_events_i[c].events[e] ?
                                core_events_i[c].weights[e] : '0;
        end

        // Adder chain over the gated weights
        // Zero extension keeps the carry of every partial sum
        always_comb begin
            sum_d = '0;
            for (int e = 0; e < CORE_EVENTS; e++) begin
                sum_d = sum_d + {{(SUM_WIDTH-WEIGHT_WIDTH){1'b0}}, gated_w[e]};
            end
        end

        // One cycle of latency and cleared with the rest of the control state
        always_ff @(posedge clk_i or negedge rstn_i) begin
            if (!rstn_i) begin
                sum_q <= '0;
            end else begin
                sum_q <= sum_d;
            end
        end

        assign ccc_sum_o[c] = sum_q;

        // No events in the previous cycle means nothing was consumed
        // whatever the weights were
        a_idle_core_zero_sum : assert property (
            @(posedge clk_i) disable iff (!rstn_i)
            $past(core_events_i[c].events == '0) |-> (ccc_sum_o[c] == '0)
        );

    end

endmodule : mccu_event_weigher

`default_nettype wire

//--- mccu_quota_monitor.sv
`timescale 1ns/1ps
`default_nettype none

// Quota tracking for one core
// Holds the software quota, takes away the registered consumed sum
// while the unit is enabled and flags an overrun before it happens
module mccu_quota_monitor (
    input  wire logic                  clk_i,
    input  wire logic                  rstn_i,
    input  wire logic                  enable_i,
    input  wire mccu_pkg::ccc_sum_t    ccc_sum_i,
    input  wire mccu_pkg::quota_ctrl_t quota_ctrl_i,
    output      mccu_pkg::quota_t      quota_o,
    output      logic                  irq_o
);

    import mccu_pkg::*;

    // Quota currently left for this core
    quota_t quota_q;

    // Next value of the quota register
    quota_t quota_d;

    // Value the consumed sum is taken from
    quota_t quota_base;

    // Consumed sum widened to the quota width
    quota_t sum_ext;

    // Base minus sum, clamped at zero
    quota_t sat_diff;

    // Sum is larger than the held quota
    logic   overrun;

    // Sum is larger than the subtraction base
    logic   base_underflow;

    // The sum is unsigned so zero padding is enough
    assign sum_ext = {{(QUOTA_WIDTH-SUM_WIDTH){1'b0}}, ccc_sum_i};

    // A fresh load bypasses the held quota in the same edge
    assign quota_base = quota_ctrl_i.update ? quota_ctrl_i.new_quota : quota_q;

    // Saturating subtraction
    assign base_underflow = sum_ext > quota_base;
    assign sat_diff       = base_underflow ? '0 : (quota_base - sum_ext);

    // Four update cases
    // Disabled holds or loads without subtraction
    // Enabled subtracts from the held or the newly loaded quota
    always_comb begin
        if (enable_i) begin
            quota_d = sat_diff;
        end else if (quota_ctrl_i.update) begin
            quota_d = quota_ctrl_i.new_quota;
        end else begin
            quota_d = quota_q;
        end
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            quota_q <= '0;
        end else begin
            quota_q <= quota_d;
        end
    end

    assign quota_o = quota_q;

    // Compared against the held quota rather than the bypassed one
    // so software sees the warning one edge before the quota hits zero
    assign overrun = sum_ext > quota_q;

    // Only an enabled unit may interrupt
    assign irq_o = enable_i && overrun;

    // Consumption never increases the budget
    a_enabled_never_grows : assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        enable_i |=> (quota_q <= $past(quota_base))
    );

    // Idle core with no load keeps its quota across the edge
    a_idle_hold : assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        (!enable_i && !quota_ctrl_i.update) |=> (quota_q == $past(quota_q))
    );

endmodule : mccu_quota_monitor

`default_nettype wire

//--- mccu_top.sv
`timescale 1ns/1ps
`default_nettype none

// Maximum-contention control unit
// One shared weigher computes the consumed sum of every core,
// then each core gets its own quota monitor
//
// Latency from the inputs
//   events to quota change   two edges
//   events to interrupt      one edge
//   update to quota_o        one edge
module mccu_top (
    input  wire logic                                          clk_i,
    input  wire logic                                          rstn_i,
    input  wire logic                                          enable_i,
    input  wire mccu_pkg::core_events_t [mccu_pkg::N_CORES-1:0] core_events_i,
    input  wire mccu_pkg::quota_ctrl_t  [mccu_pkg::N_CORES-1:0] quota_ctrl_i,
    output      mccu_pkg::quota_t       [mccu_pkg::N_CORES-1:0] quota_o,
    output      logic                   [mccu_pkg::N_CORES-1:0] irq_o
);

    import mccu_pkg::*;

    // Registered consumed sum per core, weigher to monitors
    ccc_sum_t [N_CORES-1:0] ccc_sum;

    // Sums are built every cycle, enabled or not
    mccu_event_weigher u_weigher (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .core_events_i (core_events_i),
        .ccc_sum_o     (ccc_sum)
    );

    // One monitor per core
    // Enable is shared while sums and software controls are private
    for (genvar c = 0; c < N_CORES; c++) begin : g_core
        mccu_quota_monitor u_monitor (
            .clk_i        (clk_i),
            .rstn_i       (rstn_i),
            .enable_i     (enable_i),
            .ccc_sum_i    (ccc_sum[c]),
            .quota_ctrl_i (quota_ctrl_i[c]),
            .quota_o      (quota_o[c]),
            .irq_o        (irq_o[c])
        );
    end

endmodule : mccu_top

`default_nettype wire

//--- tb_mccu.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mccu;

    import mccu_pkg::*;

    // Clock and drive timing in ns
    localparam int CLK_PERIOD  = 100;
    localparam int DRIVE_DELAY = 10;

    // Cycle budget of each phase that the watchdog adds up
    localparam int RESET_CYCLES    = 2;
    localparam int DIRECTED_CYCLES = 30;
    localparam int RANDOM_CYCLES   = 400;
    localparam int MARGIN_CYCLES   = 20;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + DIRECTED_CYCLES +
                                     RANDOM_CYCLES + MARGIN_CYCLES;

    logic                       clk_i;
    logic                       rstn_i;
    logic                       enable;
    core_events_t [N_CORES-1:0] core_events;
    quota_ctrl_t  [N_CORES-1:0] quota_ctrl;
    quota_t       [N_CORES-1:0] quota_o;
    logic         [N_CORES-1:0] irq_o;

    // Reference state with the same reset and edges as the DUT
    ccc_sum_t     [N_CORES-1:0] model_sum;
    quota_t       [N_CORES-1:0] model_quota;
    logic         [N_CORES-1:0] model_irq;

    logic [31:0] lfsr_state = 32'h55ab_2b71;
    int          error_count = 0;
    int          cycle_count = 0;

    mccu_top u_mccu_top (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .enable_i      (enable),
        .core_events_i (core_events),
        .quota_ctrl_i  (quota_ctrl),
        .quota_o       (quota_o),
        .irq_o         (irq_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD/2) clk_i = ~clk_i;
    end

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    // One LFSR step per bit handed out
    function automatic logic [31:0] random_bits(input int width);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < width; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value      = {value[30:0], lfsr_state[0]};
        end
        return value;
    endfunction

    // Active events add their weights, idle ones add nothing
    function automatic ccc_sum_t expected_sum(input core_events_t ce);
        ccc_sum_t acc;
        acc = '0;
        for (int e = 0; e < CORE_EVENTS; e++) begin
            if (ce.events[e]) begin
                acc = acc + ccc_sum_t'(ce.weights[e]);
            end
        end
        return acc;
    endfunction

    // Quota rules are hold, load, decrement, or decrement of the new load
    // and the decrement floors at zero
    function automatic quota_t next_quota(input logic en, input quota_ctrl_t ctrl,
                                          input quota_t held, input ccc_sum_t sum);
        quota_t base;
        quota_t sum_w;
        base  = ctrl.update ? ctrl.new_quota : held;
        sum_w = quota_t'(sum);
        if (!en) begin
            return base;
        end
        if (sum_w > base) begin
            return '0;
        end
        return base - sum_w;
    endfunction

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            model_sum   <= '0;
            model_quota <= '0;
        end else begin
            for (int c = 0; c < N_CORES; c++) begin
                model_sum[c]   <= expected_sum(core_events[c]);
                model_quota[c] <= next_quota(enable, quota_ctrl[c], model_quota[c],
                                             model_sum[c]);
            end
        end
    end

    // Warning whenever the registered sum is above the quota in use
    always_comb begin
        for (int c = 0; c < N_CORES; c++) begin
            model_irq[c] = enable && (quota_t'(model_sum[c]) > model_quota[c]);
        end
    end

    for (genvar c = 0; c < N_CORES; c++) begin : g_check

        // Quota and interrupt cleared while reset is held
        a_reset_clear : assert property (
            @(posedge clk_i) !rstn_i |-> (quota_o[c] == '0 && !irq_o[c])
        ) else begin
            error_count = error_count + 1;
            $display("FAIL %0t: core %0d not cleared in reset", $time, c);
        end

        a_quota_model : assert property (
            @(posedge clk_i) disable iff (!rstn_i) quota_o[c] == model_quota[c]
        ) else begin
            error_count = error_count + 1;
            $display("FAIL %0t: core %0d quota %0d, expected %0d", $time, c,
                     $sampled(quota_o[c]), $sampled(model_quota[c]));
        end

        a_irq_model : assert property (
            @(posedge clk_i) disable iff (!rstn_i) irq_o[c] == model_irq[c]
        ) else begin
            error_count = error_count + 1;
            $display("FAIL %0t: core %0d irq %0b, expected %0b", $time, c,
                     $sampled(irq_o[c]), $sampled(model_irq[c]));
        end

        // Disabled load takes new_quota as is
        a_load_disabled : assert property (
            @(posedge clk_i) disable iff (!rstn_i)
            (!enable && quota_ctrl[c].update) |=>
                quota_o[c] == $past(quota_ctrl[c].new_quota)
        ) else begin
            error_count = error_count + 1;
            $display("FAIL %0t: core %0d load while disabled gave %0d", $time, c,
                     $sampled(quota_o[c]));
        end

        // An interrupt without a reload means the quota runs out next edge
        a_irq_then_zero : assert property (
            @(posedge clk_i) disable iff (!rstn_i)
            (enable && irq_o[c] && !quota_ctrl[c].update) |=> quota_o[c] == '0
        ) else begin
            error_count = error_count + 1;
            $display("FAIL %0t: core %0d quota %0d after interrupt, expected 0",
                     $time, c, $sampled(quota_o[c]));
        end

        a_quiet_disabled : assert property (
            @(posedge clk_i) disable iff (!rstn_i) !enable |-> !irq_o[c]
        ) else begin
            error_count = error_count + 1;
            $display("FAIL %0t: core %0d interrupt while disabled", $time, c);
        end
    end

    // Advance one edge, then wait out the drive delay
    task automatic step();
        @(posedge clk_i);
        #(DRIVE_DELAY);
        cycle_count = cycle_count + 1;
    endtask

    task automatic clear_inputs();
        enable      = 1'b0;
        core_events = '0;
        quota_ctrl  = '0;
    endtask

    task automatic set_events(input int c, input logic [CORE_EVENTS-1:0] ev,
                              input weight_t [CORE_EVENTS-1:0] w);
        core_events[c].events  = ev;
        core_events[c].weights = w;
    endtask

    task automatic request_load(input int c, input quota_t value);
        quota_ctrl[c].update    = 1'b1;
        quota_ctrl[c].new_quota = value;
    endtask

    task automatic end_loads();
        for (int c = 0; c < N_CORES; c++) begin
            quota_ctrl[c].update = 1'b0;
        end
    endtask

    // Enable high about three cycles in four and reloads about one in eight
    task automatic drive_random();
        logic [31:0] bits;
        bits   = random_bits(2);
        enable = |bits[1:0];
        for (int c = 0; c < N_CORES; c++) begin
            bits = random_bits(CORE_EVENTS);
            core_events[c].events = bits[CORE_EVENTS-1:0];
            for (int e = 0; e < CORE_EVENTS; e++) begin
                core_events[c].weights[e] = weight_t'(random_bits(WEIGHT_WIDTH));
            end
            bits = random_bits(3);
            quota_ctrl[c].update    = (bits[2:0] == 3'b111);
            quota_ctrl[c].new_quota = quota_t'(random_bits(12));
        end
    endtask

    initial begin
        rstn_i = 1'b1;
        clear_inputs();
        #(DRIVE_DELAY);
        rstn_i = 1'b0;
        repeat (RESET_CYCLES) step();
        rstn_i = 1'b1;
        step();

        // Loads while disabled with events running but ignored
        request_load(0, 32'd1000);
        request_load(1, 32'd77);
        set_events(0, 4'b1111, {7'd0, 7'd10, 7'd3, 7'd5});
        set_events(1, 4'b0101, {7'd1, 7'd2, 7'd3, 7'd4});
        step();
        end_loads();
        repeat (3) step();

        // Decrement where event 3 of core 0 is active with weight zero
        enable = 1'b1;
        set_events(0, 4'b1011, {7'd0, 7'd10, 7'd3, 7'd5});
        set_events(1, 4'b0001, {7'd1, 7'd2, 7'd3, 7'd4});
        repeat (5) step();
        core_events = '0;
        repeat (2) step();

        // Small quotas against the largest sum
        enable = 1'b0;
        request_load(0, 32'd20);
        request_load(1, 32'd500);
        step();
        end_loads();
        set_events(0, 4'b1111, {7'd127, 7'd127, 7'd127, 7'd127});
        set_events(1, 4'b1111, {7'd127, 7'd127, 7'd127, 7'd127});
        step();
        enable = 1'b1;
        repeat (2) step();
        enable = 1'b0;
        repeat (2) step();

        // Reload while enabled where one core fits and one saturates
        enable = 1'b1;
        set_events(0, 4'b0011, {7'd0, 7'd0, 7'd60, 7'd40});
        step();
        request_load(0, 32'd300);
        request_load(1, 32'd300);
        step();
        end_loads();
        core_events = '0;
        repeat (3) step();

        repeat (RANDOM_CYCLES) begin
            drive_random();
            step();
        end
        clear_inputs();
        repeat (2) step();

        $display("Run ended after %0d cycles with %0d errors", cycle_count, error_count);
        if (error_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    // Stops a run that never reaches its end
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: the run did not end within %0d cycles", WATCHDOG_CYCLES);
        $display("Done: errors found");
        $finish;
    end

endmodule : tb_mccu

`default_nettype wire

//--- sources.f
mccu_pkg.sv
mccu_event_weigher.sv
mccu_quota_monitor.sv
mccu_top.sv
tb_mccu.sv

//--- Makefile
# Verilator build and run of the MCCU testbench
# Any variable below can be set on the command line, e.g. make test TOP=tb_mccu

VERILATOR ?= verilator
TOP       ?= tb_mccu
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_TEXT ?= Done: no errors

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build with Verilator, run, and check for the pass message"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS PASS_TEXT"

$(SIM_BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# Output is shown, then searched for the pass line
test: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
